//--- rv32_core.f
design/rv32_pkg.sv
design/rv32_pipe_if.sv
design/rv32_fetch.sv
design/rv32_decode.sv
design/rv32_regfile.sv
design/rv32_execute.sv
design/rv32_memory.sv
design/rv32_hazard.sv
design/rv32_core.sv
dv/rv32_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the rv32_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv32_core_tb \
  -f rv32_core.f -o rv32_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv32_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

//--- dv/rv32_core_tb.sv
`timescale 1ns/1ns

module rv32_core_tb import rv32_pkg::*; ();

  localparam int reset_cycles = 10;
  // Marker stores of branch shadows go here, real stores stay below
  localparam logic [31:0] marker_base = 32'h0000_0300;

  logic        clk;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  // Reference model of the program
  logic [31:0] ref_x [0:31];
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] rng;
  logic [11:0] slot_off;
  int          pc_w;
  int          prog_len;
  int          cyc;
  logic        built;
  logic        ebreak_seen;

  rv32_core dut0 (
    .clk, .rst_n, .imem_ren, .imem_raddr, .imem_rdata, .dmem_ren, .dmem_raddr,
    .dmem_rdata, .dmem_we, .dmem_waddr, .dmem_wdata, .ebreak
  );

  always #10 clk = ~clk;

  // Combinational SRAM models
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // ----------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------
  task automatic value_error(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("error %0t %s %h %h", $time, sig, got, exp);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic plain_error(input string msg);
    $display("%0t %s", $time, msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // ----------------------------------------------------------
  // Encoders and reference rules
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // RV32I integer result, alt selects SUB and SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    if (f3 == 3'b000) return alt ? a - b : a + b;
    if (f3 == 3'b001) return a << b[4:0];
    if (f3 == 3'b010) return {31'b0, $signed(a) < $signed(b)};
    if (f3 == 3'b011) return {31'b0, a < b};
    if (f3 == 3'b100) return a ^ b;
    if (f3 == 3'b101) return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    if (f3 == 3'b110) return a | b;
    return a & b;
  endfunction

  // ----------------------------------------------------------
  // Program builder
  // ----------------------------------------------------------
  task automatic put(input logic [31:0] ins);
    imem[pc_w] = ins;
    pc_w = pc_w + 1;
  endtask

  task automatic set_ref(input logic [4:0] rd, input logic [31:0] v);
    if (rd != 5'd0) begin
      ref_x[rd] = v;
    end
  endtask

  task automatic do_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    put(enc_r(f3, alt, rd, rs1, rs2));
    set_ref(rd, alu_ref(f3, alt, ref_x[rs1], ref_x[rs2]));
  endtask

  // For shifts imm holds shamt, bit 10 marks SRAI
  task automatic do_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [11:0] imm);
    put(enc_i(imm, rs1, f3, rd, op_imm));
    set_ref(rd, alu_ref(f3, (f3 == 3'b101) && imm[10], ref_x[rs1], sext12(imm)));
  endtask

  task automatic do_lui(input logic [4:0] rd, input logic [19:0] hi);
    put({hi, rd, op_lui});
    set_ref(rd, {hi, 12'b0});
  endtask

  // LUI then dependent ADDI with a random word
  task automatic load_rand(input logic [4:0] rd);
    rng = xorshift(rng);
    do_lui(rd, rng[31:12]);
    do_ri(3'b000, rd, rd, rng[11:0]);
  endtask

  task automatic nops(input int n);
    for (int i = 0; i < n; i++) begin
      put(instr_nop);
    end
  endtask

  // Store into the next free data slot above x1 and expect it
  task automatic store_reg(input logic [4:0] rs);
    logic [31:0] addr;
    addr = ref_x[1] + sext12(slot_off);
    put(enc_s(slot_off, rs, 5'd1));
    exp_addr.push_back(addr);
    exp_data.push_back(ref_x[rs]);
    ref_mem[addr] = ref_x[rs];
    slot_off = slot_off + 12'd4;
  endtask

  // Two shadow slots, skipped when taken, expected stores when not
  task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2);
    logic taken;
    logic [31:0] a;
    logic [31:0] b;
    a = ref_x[rs1];
    b = ref_x[rs2];
    if (f3 == 3'b000) taken = (a == b);
    else if (f3 == 3'b001) taken = (a != b);
    else if (f3 == 3'b100) taken = ($signed(a) < $signed(b));
    else taken = !($signed(a) < $signed(b));
    put(enc_b(13'd12, rs2, rs1, f3));
    if (taken) begin
      put(enc_s(12'h0, 5'd16, 5'd2));
      put(enc_s(12'h4, 5'd17, 5'd2));
    end else begin
      store_reg(5'd16);
      store_reg(5'd17);
    end
  endtask

  task automatic build_program();
    logic [11:0] ld_off;
    pc_w = 0;
    slot_off = 12'd0;
    for (int i = 0; i < 32; i++) begin
      ref_x[i] = 32'h0;
    end
    for (int i = 0; i < 256; i++) begin
      imem[i] = instr_nop;
      dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
    // x1 data base, x2 marker base, x3..x8 random operands
    do_ri(3'b000, 5'd1, 5'd0, 12'h200);
    do_ri(3'b000, 5'd2, 5'd0, marker_base[11:0]);
    for (int r = 3; r <= 8; r++) begin
      load_rand(r[4:0]);
    end
    nops(3);
    // Independent register ops
    do_rr(3'b000, 1'b0, 5'd16, 5'd3, 5'd4);
    do_rr(3'b000, 1'b1, 5'd17, 5'd5, 5'd6);
    do_rr(3'b111, 1'b0, 5'd18, 5'd7, 5'd8);
    do_rr(3'b110, 1'b0, 5'd19, 5'd3, 5'd5);
    do_rr(3'b100, 1'b0, 5'd20, 5'd4, 5'd6);
    do_rr(3'b010, 1'b0, 5'd21, 5'd7, 5'd3);
    do_rr(3'b011, 1'b0, 5'd22, 5'd8, 5'd4);
    do_rr(3'b001, 1'b0, 5'd23, 5'd5, 5'd7);
    do_rr(3'b101, 1'b0, 5'd24, 5'd6, 5'd8);
    do_rr(3'b101, 1'b1, 5'd25, 5'd3, 5'd4);
    do_lui(5'd26, 20'habcde);
    for (int r = 16; r <= 26; r++) begin
      store_reg(r[4:0]);
    end
    // Immediate forms with random operands
    for (int k = 0; k < 9; k++) begin
      rng = xorshift(rng);
      if (k < 6) begin
        do_ri(k == 0 ? 3'b000 : k == 1 ? 3'b010 : k == 2 ? 3'b011 :
              k == 3 ? 3'b100 : k == 4 ? 3'b110 : 3'b111,
              5'd16 + k[4:0], 5'd3 + k[4:0], rng[11:0]);
      end else begin
        do_ri(k == 6 ? 3'b001 : 3'b101, 5'd16 + k[4:0], 5'd3,
              {1'b0, k == 8, 5'b0, rng[4:0]});
      end
    end
    for (int r = 16; r <= 24; r++) begin
      store_reg(r[4:0]);
    end
    // Back-to-back dependent chain
    do_rr(3'b000, 1'b0, 5'd20, 5'd3, 5'd4);
    do_rr(3'b100, 1'b0, 5'd21, 5'd20, 5'd5);
    do_rr(3'b000, 1'b1, 5'd22, 5'd21, 5'd20);
    do_rr(3'b001, 1'b0, 5'd23, 5'd22, 5'd6);
    store_reg(5'd23);
    // Same chain with gaps
    do_rr(3'b000, 1'b0, 5'd20, 5'd3, 5'd4);
    nops(3);
    do_rr(3'b100, 1'b0, 5'd21, 5'd20, 5'd5);
    nops(3);
    do_rr(3'b000, 1'b1, 5'd22, 5'd21, 5'd20);
    nops(3);
    do_rr(3'b001, 1'b0, 5'd27, 5'd22, 5'd6);
    nops(3);
    store_reg(5'd27);
    // Store, dependent load, store back
    ld_off = slot_off;
    store_reg(5'd5);
    put(enc_i(ld_off, 5'd1, 3'b010, 5'd28, op_load));
    set_ref(5'd28, ref_mem[ref_x[1] + sext12(ld_off)]);
    store_reg(5'd28);
    // JAL over two marker stores, link value stored at the target
    set_ref(5'd29, 32'(pc_w * 4 + 4));
    put(enc_j(21'd12, 5'd29));
    put(enc_s(12'h8, 5'd16, 5'd2));
    put(enc_s(12'hc, 5'd17, 5'd2));
    store_reg(5'd29);
    do_branch(3'b000, 5'd3, 5'd3);
    do_branch(3'b000, 5'd3, 5'd4);
    do_branch(3'b001, 5'd3, 5'd3);
    do_branch(3'b001, 5'd3, 5'd4);
    do_branch(3'b100, 5'd3, 5'd4);
    do_branch(3'b100, 5'd4, 5'd3);
    do_branch(3'b101, 5'd5, 5'd6);
    do_branch(3'b101, 5'd5, 5'd5);
    // Halt, nothing after it may store
    put(instr_ebreak);
    put(enc_s(12'h10, 5'd16, 5'd2));
    put(enc_s(12'h14, 5'd17, 5'd2));
    nops(4);
    prog_len = pc_w;
  endtask

  // ----------------------------------------------------------
  // Checks, sampled mid-cycle where outputs are settled
  // ----------------------------------------------------------
  always @(negedge clk) begin
    // PC sits at zero through reset and the first fetch after it
    if (cyc >= 1 && cyc <= reset_cycles) begin
      assert (imem_raddr == 32'h0) else value_error("imem_raddr", imem_raddr, 32'h0);
    end
    // First instruction reaches memory three cycles after reset release
    if (cyc >= 1 && cyc <= reset_cycles + 2) begin
      assert (!dmem_we) else value_error("dmem_we", {31'b0, dmem_we}, 32'h0);
      assert (!dmem_ren) else value_error("dmem_ren", {31'b0, dmem_ren}, 32'h0);
      assert (!ebreak) else value_error("ebreak", {31'b0, ebreak}, 32'h0);
    end
    if (cyc >= 1 && dmem_we) begin
      assert (!ebreak) else plain_error("Store issued after the core halted");
      assert (dmem_waddr < marker_base)
        else plain_error("Store reached a branch shadow marker address");
      assert (exp_addr.size() != 0) else plain_error("Store issued with none expected");
      assert (dmem_waddr == exp_addr[0])
        else value_error("dmem_waddr", dmem_waddr, exp_addr[0]);
      assert (dmem_wdata == exp_data[0])
        else value_error("dmem_wdata", dmem_wdata, exp_data[0]);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end
    if (ebreak_seen) begin
      assert (ebreak) else value_error("ebreak", {31'b0, ebreak}, 32'h1);
      // Halted core holds the PC, so fetch stays off
      assert (!imem_ren) else value_error("imem_ren", {31'b0, imem_ren}, 32'h0);
    end
    if (cyc >= 1 && ebreak && !ebreak_seen) begin
      assert (exp_addr.size() == 0)
        else plain_error("Core halted before all expected stores were seen");
      ebreak_seen = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cyc = 0;
    built = 1'b0;
    ebreak_seen = 1'b0;
    rng = 32'h3c857574;
    build_program();
    built = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2 rst_n = 1'b1;
    wait (ebreak_seen);
    repeat (5) @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

  initial begin
    wait (built);
    repeat (prog_len * 8 + reset_cycles) @(posedge clk);
    $display("Timeout, the core never halted");
    $display("Done: errors found");
    $fatal(1);
  end

endmodule

//--- design/rv32_core.sv
`timescale 1ns/1ns

module rv32_core import rv32_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output logic  imem_ren,
  output word_t imem_raddr,
  input  word_t imem_rdata,
  output logic  dmem_ren,
  output word_t dmem_raddr,
  input  word_t dmem_rdata,
  output logic  dmem_we,
  output word_t dmem_waddr,
  output word_t dmem_wdata,
  output logic  ebreak
);

  // IF -> ID
  word_t    instr_id;
  word_t    pc_id;
  // ID <-> regfile, ID -> hazard
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     rs1_used;
  logic     rs2_used;
  word_t    rs1_data;
  word_t    rs2_data;
  // EX -> IF and hazard
  logic     redirect;
  word_t    redirect_pc;
  // MEM -> regfile
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;
  word_t    dmem_addr;
  logic     halted;
  // Hazard controls
  logic     stall_pc;
  logic     stall_if_id;
  logic     flush_if_id;
  logic     flush_id_ex;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  // ----------------------------------------------------------
  // Pipeline stages
  // ----------------------------------------------------------
  rv32_fetch fetch0 (
    .clk, .rst_n, .stall_pc, .stall_if_id, .flush_if_id, .redirect, .redirect_pc,
    .imem_rdata, .imem_raddr, .instr_id, .pc_id
  );

  rv32_decode decode0 (
    .clk, .rst_n, .instr_id, .pc_id, .flush_id_ex, .rs1, .rs2, .rs1_used, .rs2_used,
    .rs1_data, .rs2_data, .id_ex(id_ex.src)
  );

  rv32_regfile regfile0 (
    .clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data,
    .we(wb_we), .wr_addr(wb_rd), .wr_data(wb_data)
  );

  rv32_execute execute0 (
    .clk, .rst_n, .id_ex(id_ex.dst), .ex_mem(ex_mem.src), .redirect, .redirect_pc
  );

  rv32_memory memory0 (
    .clk, .rst_n, .ex_mem(ex_mem.dst), .dmem_ren, .dmem_we, .dmem_addr, .dmem_wdata,
    .dmem_rdata, .wb_we, .wb_rd, .wb_data, .halted
  );

  rv32_hazard hazard0 (
    .rs1, .rs2, .rs1_used, .rs2_used, .id_ex(id_ex.mon), .ex_mem(ex_mem.mon),
    .redirect, .halted, .stall_pc, .stall_if_id, .flush_if_id, .flush_id_ex
  );

  // No fetch while the PC is held
  assign imem_ren = !stall_pc;
  // Word access only, reads and writes share one address
  assign dmem_raddr = dmem_addr;
  assign dmem_waddr = dmem_addr;
  assign ebreak = halted;

endmodule

//--- design/rv32_hazard.sv
`timescale 1ns/1ns

module rv32_hazard import rv32_pkg::*; (
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     rs1_used,
  input  logic     rs2_used,
  id_ex_if.mon     id_ex,
  ex_mem_if.mon    ex_mem,
  input  logic     redirect,
  input  logic     halted,
  output logic     stall_pc,
  output logic     stall_if_id,
  output logic     flush_if_id,
  output logic     flush_id_ex
);

  logic data_hazard;
  logic hold;

  // One source against one producer, x0 never creates a dependence
  function automatic logic depends(input reg_idx_t rd, input logic wr, input reg_idx_t src,
                                   input logic used);
    return used && wr && (rd != '0) && (rd == src);
  endfunction

  // RAW against EX and MEM, WB is covered by the write-through regfile
  assign data_hazard = depends(id_ex.rd, id_ex.reg_write, rs1, rs1_used) ||
                       depends(id_ex.rd, id_ex.reg_write, rs2, rs2_used) ||
                       depends(ex_mem.rd, ex_mem.reg_write, rs1, rs1_used) ||
                       depends(ex_mem.rd, ex_mem.reg_write, rs2, rs2_used);

  // Redirect kills the dependent instruction anyway, so no hold then
  assign hold = data_hazard && !redirect;

  // Halt freezes the PC, everything younger is flushed
  assign stall_pc = halted || hold;
  assign stall_if_id = hold;
  assign flush_if_id = redirect || halted;
  // Bubble into EX on a hold, on the branch shadow, or after halt
  assign flush_id_ex = redirect || halted || data_hazard;

endmodule

//--- design/rv32_memory.sv
`timescale 1ns/1ns

module rv32_memory import rv32_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  ex_mem_if.dst    ex_mem,
  output logic     dmem_ren,
  output logic     dmem_we,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  input  word_t    dmem_rdata,
  output logic     wb_we,
  output reg_idx_t wb_rd,
  output word_t    wb_data,
  output logic     halted
);

  res_sel_t res_sel_wb;
  word_t    alu_result_wb;
  word_t    load_data_wb;
  word_t    pc_plus4_wb;

  // ----------------------------------------------------------
  // Data memory access
  // ----------------------------------------------------------

  // Strobes die once halted, so nothing younger than EBREAK stores
  assign dmem_ren = ex_mem.valid && ex_mem.mem_read && !halted;
  assign dmem_we = ex_mem.valid && ex_mem.mem_write && !halted;
  assign dmem_addr = ex_mem.alu_result;
  assign dmem_wdata = ex_mem.store_data;

  // Sticky halt, cleared only by reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
      wb_we <= 1'b0;
    end else begin
      wb_we <= ex_mem.valid && ex_mem.reg_write && !halted;
      if (ex_mem.valid && ex_mem.is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // MEM/WB register and write-back select
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    wb_rd <= ex_mem.rd;
    res_sel_wb <= ex_mem.res_sel;
    alu_result_wb <= ex_mem.alu_result;
    // SRAM read data is valid in the same cycle as dmem_ren
    load_data_wb <= dmem_rdata;
    pc_plus4_wb <= ex_mem.pc_plus4;
  end

  always_comb begin
    case (res_sel_wb)
      res_mem: wb_data = load_data_wb;
      res_pc4: wb_data = pc_plus4_wb;
      default: wb_data = alu_result_wb;
    endcase
  end

endmodule

//--- design/rv32_execute.sv
`timescale 1ns/1ns

module rv32_execute import rv32_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  id_ex_if.dst  id_ex,
  ex_mem_if.src ex_mem,
  output logic  redirect,
  output word_t redirect_pc
);

  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       taken;

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------
  assign alu_a = id_ex.rs1_data;
  assign alu_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (id_ex.alu_op)
      alu_add:    alu_result = alu_a + alu_b;
      alu_sub:    alu_result = alu_a - alu_b;
      alu_and:    alu_result = alu_a & alu_b;
      alu_or:     alu_result = alu_a | alu_b;
      alu_xor:    alu_result = alu_a ^ alu_b;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, alu_a < alu_b};
      alu_sll:    alu_result = alu_a << shamt;
      alu_srl:    alu_result = alu_a >> shamt;
      alu_sra:    alu_result = word_t'($signed(alu_a) >>> shamt);
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Branch resolve
  // ----------------------------------------------------------
  assign eq = (id_ex.rs1_data == id_ex.rs2_data);
  assign lt = $signed(id_ex.rs1_data) < $signed(id_ex.rs2_data);

  // BEQ, BNE, BLT, BGE, unsigned forms never taken
  always_comb begin
    case (id_ex.funct3)
      3'b000:  taken = eq;
      3'b001:  taken = !eq;
      3'b100:  taken = lt;
      3'b101:  taken = !lt;
      default: taken = 1'b0;
    endcase
  end

  // JAL and branches share the pc+imm target
  assign redirect = id_ex.valid && (id_ex.is_jump || (id_ex.is_branch && taken));
  assign redirect_pc = id_ex.pc + id_ex.imm;

  // ----------------------------------------------------------
  // EX/MEM register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.is_ebreak <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
      ex_mem.reg_write <= id_ex.reg_write;
      ex_mem.mem_read <= id_ex.mem_read;
      ex_mem.mem_write <= id_ex.mem_write;
      ex_mem.is_ebreak <= id_ex.is_ebreak;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem.rd <= id_ex.rd;
    ex_mem.res_sel <= id_ex.res_sel;
    ex_mem.alu_result <= alu_result;
    // SW data is rs2 untouched
    ex_mem.store_data <= id_ex.rs2_data;
    ex_mem.pc_plus4 <= id_ex.pc + 32'd4;
  end

endmodule

//--- design/rv32_regfile.sv
`timescale 1ns/1ns

module rv32_regfile import rv32_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t wr_addr,
  input  word_t    wr_data
);

  // x1..x31 only, x0 has no storage
  word_t regs [1:31];

  // One read port
  // Same-cycle write shows through so WB needs no hazard check
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (we && (wr_addr == idx)) begin
      return wr_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst_n && we && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule

//--- design/rv32_decode.sv
`timescale 1ns/1ns

module rv32_decode import rv32_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  word_t    instr_id,
  input  word_t    pc_id,
  input  logic     flush_id_ex,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     rs1_used,
  output logic     rs2_used,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  id_ex_if.src     id_ex
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       known;
  logic       reg_write;
  logic       use_imm;
  logic       is_branch;
  logic       is_jump;
  logic       mem_read;
  logic       mem_write;
  logic       is_ebreak;
  alu_op_t    alu_op;
  res_sel_t   res_sel;
  word_t      imm;

  // funct3 to ALU op, sub_sra picks SUB over ADD and SRA over SRL
  function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sub_sra ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = instr_id[6:0];
  assign funct3 = instr_id[14:12];
  // funct7 bit 5
  assign alt = instr_id[30];
  assign rs1 = instr_id[19:15];
  assign rs2 = instr_id[24:20];

  // ----------------------------------------------------------
  // Control and immediate decode
  // ----------------------------------------------------------
  always_comb begin
    known = 1'b1;
    reg_write = 1'b0;
    use_imm = 1'b0;
    is_branch = 1'b0;
    is_jump = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    is_ebreak = 1'b0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    alu_op = alu_add;
    res_sel = res_alu;
    // I-type by default
    imm = {{20{instr_id[31]}}, instr_id[31:20]};
    case (opcode)
      op_lui: begin
        reg_write = 1'b1;
        use_imm = 1'b1;
        alu_op = alu_pass_b;
        imm = {instr_id[31:12], 12'b0};
      end
      op_jal: begin
        // Link value is pc+4, target computed in execute
        reg_write = 1'b1;
        is_jump = 1'b1;
        res_sel = res_pc4;
        imm = {{11{instr_id[31]}}, instr_id[31], instr_id[19:12], instr_id[20],
               instr_id[30:21], 1'b0};
      end
      op_branch: begin
        is_branch = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        imm = {{19{instr_id[31]}}, instr_id[31], instr_id[7], instr_id[30:25],
               instr_id[11:8], 1'b0};
      end
      op_load: begin
        reg_write = 1'b1;
        mem_read = 1'b1;
        use_imm = 1'b1;
        res_sel = res_mem;
        rs1_used = 1'b1;
      end
      op_store: begin
        mem_write = 1'b1;
        use_imm = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        imm = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
      end
      op_imm: begin
        // Bit 30 only matters for SRAI, ADDI has no SUB form
        reg_write = 1'b1;
        use_imm = 1'b1;
        rs1_used = 1'b1;
        alu_op = alu_fn(funct3, alt && (funct3 == 3'b101));
      end
      op_reg: begin
        reg_write = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        alu_op = alu_fn(funct3, alt);
      end
      op_system: begin
        // EBREAK only, anything else becomes a bubble
        is_ebreak = (instr_id == instr_ebreak);
        known = is_ebreak;
      end
      default: known = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // ID/EX register
  // ----------------------------------------------------------

  // Flush or stall inserts a bubble with every strobe low
  always_ff @(posedge clk) begin
    if (!rst_n || flush_id_ex) begin
      id_ex.valid <= 1'b0;
      id_ex.reg_write <= 1'b0;
      id_ex.is_branch <= 1'b0;
      id_ex.is_jump <= 1'b0;
      id_ex.mem_read <= 1'b0;
      id_ex.mem_write <= 1'b0;
      id_ex.is_ebreak <= 1'b0;
    end else begin
      id_ex.valid <= known;
      id_ex.reg_write <= reg_write;
      id_ex.is_branch <= is_branch;
      id_ex.is_jump <= is_jump;
      id_ex.mem_read <= mem_read;
      id_ex.mem_write <= mem_write;
      id_ex.is_ebreak <= is_ebreak;
    end
  end

  // Operands and fields
  always_ff @(posedge clk) begin
    id_ex.rd <= instr_id[11:7];
    id_ex.rs1_data <= rs1_data;
    id_ex.rs2_data <= rs2_data;
    id_ex.imm <= imm;
    id_ex.pc <= pc_id;
    id_ex.alu_op <= alu_op;
    id_ex.use_imm <= use_imm;
    id_ex.res_sel <= res_sel;
    id_ex.funct3 <= funct3;
  end

endmodule

//--- design/rv32_fetch.sv
`timescale 1ns/1ns

module rv32_fetch import rv32_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall_pc,
  input  logic  stall_if_id,
  input  logic  flush_if_id,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  word_t imem_rdata,
  output word_t imem_raddr,
  output word_t instr_id,
  output word_t pc_id
);

  word_t pc;
  word_t pc_next;

  // Instruction SRAM is combinational, address is the live PC
  assign imem_raddr = pc;

  // Hold on stall or halt, jump on redirect, else next word
  always_comb begin
    if (stall_pc) begin
      pc_next = pc;
    end else if (redirect) begin
      pc_next = redirect_pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // ----------------------------------------------------------
  // IF/ID register
  // ----------------------------------------------------------

  // Flush beats stall, the slot turns into a nop
  always_ff @(posedge clk) begin
    if (!rst_n || flush_if_id) begin
      instr_id <= instr_nop;
    end else if (!stall_if_id) begin
      instr_id <= imem_rdata;
    end
  end

  // PC of the word now in decode
  always_ff @(posedge clk) begin
    if (!stall_if_id) begin
      pc_id <= pc;
    end
  end

endmodule

//--- design/rv32_pipe_if.sv
`timescale 1ns/1ns

// ID/EX pipeline register contents
// Decode drives it, execute consumes it, hazard unit snoops rd
interface id_ex_if import rv32_pkg::*; ();
  logic       valid;
  logic       reg_write;
  reg_idx_t   rd;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      imm;
  word_t      pc;
  alu_op_t    alu_op;
  logic       use_imm;
  res_sel_t   res_sel;
  logic       is_branch;
  logic       is_jump;
  logic [2:0] funct3;
  logic       mem_read;
  logic       mem_write;
  logic       is_ebreak;

  modport src (output valid, reg_write, rd, rs1_data, rs2_data, imm, pc, alu_op, use_imm,
               res_sel, is_branch, is_jump, funct3, mem_read, mem_write, is_ebreak);
  modport dst (input valid, reg_write, rd, rs1_data, rs2_data, imm, pc, alu_op, use_imm,
               res_sel, is_branch, is_jump, funct3, mem_read, mem_write, is_ebreak);
  // Dependence check only needs the destination
  modport mon (input rd, reg_write);
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if import rv32_pkg::*; ();
  logic     valid;
  logic     reg_write;
  reg_idx_t rd;
  res_sel_t res_sel;
  word_t    alu_result;
  word_t    store_data;
  word_t    pc_plus4;
  logic     mem_read;
  logic     mem_write;
  logic     is_ebreak;

  modport src (output valid, reg_write, rd, res_sel, alu_result, store_data, pc_plus4,
               mem_read, mem_write, is_ebreak);
  modport dst (input valid, reg_write, rd, res_sel, alu_result, store_data, pc_plus4,
               mem_read, mem_write, is_ebreak);
  modport mon (input rd, reg_write);
endinterface

//--- design/rv32_pkg.sv
package rv32_pkg;

  // ----------------------------------------------------------
  // Widths and basic types
  // ----------------------------------------------------------

  // Data and address width
  localparam int xlen = 32;
  // Register index width, 32 architectural registers
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // ALU operations
  // pass_b forwards operand b unchanged, used by LUI
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_t;

  // Write-back source
  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_pc4
  } res_sel_t;

  // ----------------------------------------------------------
  // RV32I opcodes of the supported subset
  // ----------------------------------------------------------
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // ADDI x0,x0,0 fills flushed slots
  localparam word_t instr_nop = 32'h0000_0013;
  // Only SYSTEM encoding the core accepts
  localparam word_t instr_ebreak = 32'h0010_0073;

endpackage
